//--- hdl/address_decoder.sv
// Control register decoder and command builder
`default_nettype none
`include "mchan_cfg.svh"

module address_decoder (
   input  wire logic                           clk_i,
   input  wire logic                           rst_n_i,
   input  wire mchan_pkg::ctrl_req_t           ctrl_targ_i,
   output mchan_pkg::ctrl_rsp_t                ctrl_targ_o,
   output logic                                alloc_req_o,
   input  wire logic                           alloc_gnt_i,
   input  wire logic [`MCHAN_SID_WIDTH-1:0]    alloc_sid_i,
   output logic [`MCHAN_NB_TRANSFERS-1:0]      free_o,
   output logic                                issue_o,
   output logic [`MCHAN_SID_WIDTH-1:0]         issue_sid_o,
   input  wire logic [`MCHAN_NB_TRANSFERS-1:0] pending_i,
   output logic                                tcdm_push_req_o,
   input  wire logic                           tcdm_push_gnt_i,
   output logic                                ext_push_req_o,
   input  wire logic                           ext_push_gnt_i,
   output logic                                cmd_push_req_o,
   input  wire logic                           cmd_push_gnt_i,
   output mchan_pkg::cmd_entry_t               cmd_entry_o,
   output logic [`MCHAN_TCDM_ADD_WIDTH-1:0]    tcdm_add_o,
   output logic [`MCHAN_EXT_ADD_WIDTH-1:0]     ext_add_o,
   output logic                                seq_busy_o
);

   localparam int NB = `MCHAN_NB_TRANSFERS;
   localparam int SW = `MCHAN_SID_WIDTH;

   localparam logic [3:0] CMD_OFF    = `MCHAN_CMD_OFFSET;
   localparam logic [3:0] STATUS_OFF = `MCHAN_STATUS_OFFSET;

   // Sequence states
   localparam logic [1:0] ST_CMD  = 2'd0;
   localparam logic [1:0] ST_TCDM = 2'd1;
   localparam logic [1:0] ST_EXT  = 2'd2;
   localparam logic [1:0] ST_TWD  = 2'd3;

   logic [1:0]             state_q;
   logic [1:0]             state_d;
   mchan_pkg::ctrl_word_u  wdata;
   mchan_pkg::cmd_word_t   cmd_q;
   logic [SW-1:0]          sid_q;
   logic                   sel_cmd;
   logic                   sel_status;
   logic                   rd;
   logic                   wr_cmd;
   logic                   gnt;
   logic                   r_valid_q;
   logic [31:0]            r_data_q;
   logic [31:0]            rd_data;

   //**********************************************************
   // Access decode
   //**********************************************************
   assign wdata      = ctrl_targ_i.data;
   assign sel_cmd    = (ctrl_targ_i.add[3:2] == CMD_OFF[3:2]);
   assign sel_status = (ctrl_targ_i.add[3:2] == STATUS_OFF[3:2]);
   assign rd         = ctrl_targ_i.req & ctrl_targ_i.typ;
   assign wr_cmd     = ctrl_targ_i.req & ~ctrl_targ_i.typ & sel_cmd;

   // CMD read asks for a SID, STATUS write releases SIDs
   assign alloc_req_o = rd & sel_cmd;
   assign free_o      = (ctrl_targ_i.req & ~ctrl_targ_i.typ & sel_status) ?
                        ctrl_targ_i.data[NB-1:0] : '0;

   //**********************************************************
   // Sequence FSM and queue pushes
   //**********************************************************
   always_comb begin
      state_d         = state_q;
      gnt             = 1'b1;
      tcdm_push_req_o = 1'b0;
      ext_push_req_o  = 1'b0;
      cmd_push_req_o  = 1'b0;
      if (wr_cmd) begin
         case (state_q)
            ST_CMD: state_d = ST_TCDM;
            ST_TCDM: begin
               gnt             = tcdm_push_gnt_i;
               tcdm_push_req_o = tcdm_push_gnt_i;
               if (gnt)
                  state_d = ST_EXT;
            end
            ST_EXT: begin
               // 1D command closes here, so the command queue needs room too
               gnt            = ext_push_gnt_i & (cmd_q.twd | cmd_push_gnt_i);
               ext_push_req_o = gnt;
               cmd_push_req_o = gnt & ~cmd_q.twd;
               if (gnt)
                  state_d = cmd_q.twd ? ST_TWD : ST_CMD;
            end
            default: begin
               gnt            = cmd_push_gnt_i;
               cmd_push_req_o = cmd_push_gnt_i;
               if (gnt)
                  state_d = ST_CMD;
            end
         endcase
      end
   end

   assign issue_o     = cmd_push_req_o;
   assign issue_sid_o = sid_q;
   assign seq_busy_o  = (state_q != ST_CMD);

   // Addresses go straight from write data into their queues
   assign tcdm_add_o = ctrl_targ_i.data[`MCHAN_TCDM_ADD_WIDTH-1:0];
   assign ext_add_o  = ctrl_targ_i.data[`MCHAN_EXT_ADD_WIDTH-1:0];

   // Entry from the latched command word, 2D part only on the TWD word
   always_comb begin
      cmd_entry_o.len    = cmd_q.len;
      cmd_entry_o.opc    = cmd_q.opc;
      cmd_entry_o.inc    = cmd_q.inc;
      cmd_entry_o.twd    = cmd_q.twd;
      cmd_entry_o.ele    = cmd_q.ele;
      cmd_entry_o.ile    = cmd_q.ile;
      cmd_entry_o.ble    = cmd_q.ble;
      cmd_entry_o.sid    = sid_q;
      cmd_entry_o.count  = (state_q == ST_TWD) ? wdata.twd.count : '0;
      cmd_entry_o.stride = (state_q == ST_TWD) ? wdata.twd.stride : '0;
   end

   //**********************************************************
   // Read response
   //**********************************************************
   always_comb begin
      rd_data = '0;
      if (rd && sel_cmd)
         rd_data = alloc_gnt_i ? {{(32 - SW){1'b0}}, alloc_sid_i} : 32'h8000_0000;
      else if (rd && sel_status)
         rd_data = {{(32 - NB){1'b0}}, pending_i};
   end

   assign ctrl_targ_o = '{gnt: ctrl_targ_i.req & gnt, r_valid: r_valid_q, r_data: r_data_q};

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= ST_CMD;
         r_valid_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         r_valid_q <= ctrl_targ_i.req & gnt;
      end
   end

   // Command word, current SID and read data
   always_ff @(posedge clk_i) begin
      if (wr_cmd && state_q == ST_CMD)
         cmd_q <= wdata.cmd;
      if (alloc_req_o && alloc_gnt_i)
         sid_q <= alloc_sid_i;
      if (ctrl_targ_i.req && gnt)
         r_data_q <= rd_data;
   end

endmodule

`default_nettype wire

//--- hdl/core_if.sv
// Core interface with command queues
`default_nettype none
`include "mchan_cfg.svh"

module core_if (
   input  wire logic                           clk_i,
   input  wire logic                           rst_n_i,
   input  wire mchan_pkg::ctrl_req_t           ctrl_targ_i,
   output mchan_pkg::ctrl_rsp_t                ctrl_targ_o,
   output logic                                alloc_req_o,
   input  wire logic                           alloc_gnt_i,
   input  wire logic [`MCHAN_SID_WIDTH-1:0]    alloc_sid_i,
   output logic [`MCHAN_NB_TRANSFERS-1:0]      free_o,
   output logic                                issue_o,
   output logic [`MCHAN_SID_WIDTH-1:0]         issue_sid_o,
   input  wire logic [`MCHAN_NB_TRANSFERS-1:0] pending_i,
   output logic                                cmd_req_o,
   input  wire logic                           cmd_gnt_i,
   output mchan_pkg::mchan_cmd_t               cmd_o,
   output logic                                busy_o
);

   localparam int ENTRY_W = $bits(mchan_pkg::cmd_entry_t);
   localparam int TCDM_W  = `MCHAN_TCDM_ADD_WIDTH;
   localparam int EXT_W   = `MCHAN_EXT_ADD_WIDTH;

   mchan_pkg::cmd_entry_t push_entry;
   mchan_pkg::cmd_entry_t pop_entry;
   logic [TCDM_W-1:0]     push_tcdm;
   logic [TCDM_W-1:0]     pop_tcdm;
   logic [EXT_W-1:0]      push_ext;
   logic [EXT_W-1:0]      pop_ext;
   logic                  cmd_push_req;
   logic                  cmd_push_gnt;
   logic                  cmd_valid;
   logic                  cmd_empty;
   logic                  tcdm_push_req;
   logic                  tcdm_push_gnt;
   logic                  tcdm_valid;
   logic                  tcdm_empty;
   logic                  ext_push_req;
   logic                  ext_push_gnt;
   logic                  ext_valid;
   logic                  ext_empty;
   logic                  seq_busy;
   logic                  pop;

   //**********************************************************
   // Register decoder
   //**********************************************************
   address_decoder i_decoder (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .ctrl_targ_i     (ctrl_targ_i),
      .ctrl_targ_o     (ctrl_targ_o),
      .alloc_req_o     (alloc_req_o),
      .alloc_gnt_i     (alloc_gnt_i),
      .alloc_sid_i     (alloc_sid_i),
      .free_o          (free_o),
      .issue_o         (issue_o),
      .issue_sid_o     (issue_sid_o),
      .pending_i       (pending_i),
      .tcdm_push_req_o (tcdm_push_req),
      .tcdm_push_gnt_i (tcdm_push_gnt),
      .ext_push_req_o  (ext_push_req),
      .ext_push_gnt_i  (ext_push_gnt),
      .cmd_push_req_o  (cmd_push_req),
      .cmd_push_gnt_i  (cmd_push_gnt),
      .cmd_entry_o     (push_entry),
      .tcdm_add_o      (push_tcdm),
      .ext_add_o       (push_ext),
      .seq_busy_o      (seq_busy)
   );

   //**********************************************************
   // Command, TCDM address and ext address queues
   //**********************************************************
   mchan_fifo #(.DATA_WIDTH(ENTRY_W), .DATA_DEPTH(`MCHAN_QUEUE_DEPTH)) i_cmd_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .push_req_i (cmd_push_req),
      .push_dat_i (push_entry),
      .push_gnt_o (cmd_push_gnt),
      .pop_req_i  (pop),
      .pop_dat_o  (pop_entry),
      .pop_gnt_o  (cmd_valid),
      .empty_o    (cmd_empty)
   );

   mchan_fifo #(.DATA_WIDTH(TCDM_W), .DATA_DEPTH(`MCHAN_QUEUE_DEPTH)) i_tcdm_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .push_req_i (tcdm_push_req),
      .push_dat_i (push_tcdm),
      .push_gnt_o (tcdm_push_gnt),
      .pop_req_i  (pop),
      .pop_dat_o  (pop_tcdm),
      .pop_gnt_o  (tcdm_valid),
      .empty_o    (tcdm_empty)
   );

   mchan_fifo #(.DATA_WIDTH(EXT_W), .DATA_DEPTH(`MCHAN_QUEUE_DEPTH)) i_ext_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .push_req_i (ext_push_req),
      .push_dat_i (push_ext),
      .push_gnt_o (ext_push_gnt),
      .pop_req_i  (pop),
      .pop_dat_o  (pop_ext),
      .pop_gnt_o  (ext_valid),
      .empty_o    (ext_empty)
   );

   //**********************************************************
   // Join and common pop
   //**********************************************************
   assign cmd_req_o = cmd_valid & tcdm_valid & ext_valid;
   assign pop       = cmd_req_o & cmd_gnt_i;
   assign cmd_o     = '{entry: pop_entry, tcdm_add: pop_tcdm, ext_add: pop_ext};

   // Mid-sequence, queued work or transfers in flight
   assign busy_o = seq_busy | ~(cmd_empty & tcdm_empty & ext_empty) | (|pending_i);

   // Offered command holds until taken
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_req_o && !cmd_gnt_i |=> cmd_req_o && $stable(cmd_o));

endmodule

`default_nettype wire

//--- hdl/mchan_cfg.svh
// DMA channel configuration
`ifndef MCHAN_CFG_SVH
`define MCHAN_CFG_SVH

// SID pool
`define MCHAN_NB_TRANSFERS      4
`define MCHAN_SID_WIDTH         2

// Entries per command, TCDM and ext queue
`define MCHAN_QUEUE_DEPTH       2

// Command fields
`define MCHAN_LEN_WIDTH         16
`define MCHAN_OPC_WIDTH         1
`define MCHAN_TCDM_ADD_WIDTH    12
`define MCHAN_EXT_ADD_WIDTH     29
`define MCHAN_TWD_COUNT_WIDTH   16
`define MCHAN_TWD_STRIDE_WIDTH  16

// Register map, word address bits 3:2 pick the register
`define MCHAN_CMD_OFFSET        4'h0
`define MCHAN_STATUS_OFFSET     4'h4

`endif

//--- hdl/mchan_ctrl.sv
// DMA channel command front end
`default_nettype none
`include "mchan_cfg.svh"

module mchan_ctrl (
   input  wire logic                        clk_i,
   input  wire logic                        rst_n_i,
   input  wire mchan_pkg::ctrl_req_t        ctrl_targ_i,
   output mchan_pkg::ctrl_rsp_t             ctrl_targ_o,
   output logic                             cmd_req_o,
   input  wire logic                        cmd_gnt_i,
   output mchan_pkg::mchan_cmd_t            cmd_o,
   input  wire logic                        done_i,
   input  wire logic [`MCHAN_SID_WIDTH-1:0] done_sid_i,
   output logic                             busy_o
);

   logic                           alloc_req;
   logic                           alloc_gnt;
   logic [`MCHAN_SID_WIDTH-1:0]    alloc_sid;
   logic [`MCHAN_NB_TRANSFERS-1:0] free;
   logic                           issue;
   logic [`MCHAN_SID_WIDTH-1:0]    issue_sid;
   logic [`MCHAN_NB_TRANSFERS-1:0] pending;

   // Register target, queues and join
   core_if i_core_if (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .ctrl_targ_i (ctrl_targ_i),
      .ctrl_targ_o (ctrl_targ_o),
      .alloc_req_o (alloc_req),
      .alloc_gnt_i (alloc_gnt),
      .alloc_sid_i (alloc_sid),
      .free_o      (free),
      .issue_o     (issue),
      .issue_sid_o (issue_sid),
      .pending_i   (pending),
      .cmd_req_o   (cmd_req_o),
      .cmd_gnt_i   (cmd_gnt_i),
      .cmd_o       (cmd_o),
      .busy_o      (busy_o)
   );

   // SID pool
   trans_allocator i_allocator (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .alloc_req_i (alloc_req),
      .alloc_gnt_o (alloc_gnt),
      .alloc_sid_o (alloc_sid),
      .free_i      (free),
      .issue_i     (issue),
      .issue_sid_i (issue_sid),
      .done_i      (done_i),
      .done_sid_i  (done_sid_i),
      .pending_o   (pending)
   );

endmodule

`default_nettype wire

//--- hdl/mchan_fifo.sv
// First-word-fall-through queue
`default_nettype none

module mchan_fifo #(
   parameter int DATA_WIDTH = 32,
   parameter int DATA_DEPTH = 2
) (
   input  wire logic                  clk_i,
   input  wire logic                  rst_n_i,
   input  wire logic                  push_req_i,
   input  wire logic [DATA_WIDTH-1:0] push_dat_i,
   output logic                       push_gnt_o,
   input  wire logic                  pop_req_i,
   output logic [DATA_WIDTH-1:0]      pop_dat_o,
   output logic                       pop_gnt_o,
   output logic                       empty_o
);

   localparam int AW = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;

   logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic [AW:0]           count;
   logic                  push;
   logic                  pop;

   // Not full, not empty
   assign push_gnt_o = (count != (AW+1)'(DATA_DEPTH));
   assign pop_gnt_o  = (count != '0);
   assign empty_o    = ~pop_gnt_o;

   assign push = push_req_i & push_gnt_o;
   assign pop  = pop_req_i & pop_gnt_o;

   // Head word always on the output
   assign pop_dat_o = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(DATA_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DATA_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         // Occupancy
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (push)
         mem[wr_ptr] <= push_dat_i;
   end

   // Producers only push into room, consumers only pop real data
   assert property (@(posedge clk_i) disable iff (!rst_n_i) push_req_i |-> push_gnt_o);
   assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_req_i |-> pop_gnt_o);

endmodule

`default_nettype wire

//--- hdl/mchan_pkg.sv
// DMA channel types
`default_nettype none
`include "mchan_cfg.svh"

package mchan_pkg;

   // Control target request, typ high means read
   typedef struct packed {
      logic        req;
      logic        typ;
      logic [3:0]  be;
      logic [31:0] add;
      logic [31:0] data;
   } ctrl_req_t;

   // Control target response
   typedef struct packed {
      logic        gnt;
      logic        r_valid;
      logic [31:0] r_data;
   } ctrl_rsp_t;

   // Command register layout
   typedef struct packed {
      logic [31-`MCHAN_LEN_WIDTH-`MCHAN_OPC_WIDTH-5:0] rsvd;
      logic                                            ble;
      logic                                            ile;
      logic                                            ele;
      logic                                            twd;
      logic                                            inc;
      logic [`MCHAN_OPC_WIDTH-1:0]                     opc;
      logic [`MCHAN_LEN_WIDTH-1:0]                     len;
   } cmd_word_t;

   // 2D descriptor layout
   typedef struct packed {
      logic [`MCHAN_TWD_STRIDE_WIDTH-1:0] stride;
      logic [`MCHAN_TWD_COUNT_WIDTH-1:0]  count;
   } twd_word_t;

   // One write-data word, seen as a command or as a 2D word
   typedef union packed {
      cmd_word_t cmd;
      twd_word_t twd;
   } ctrl_word_u;

   // Command queue entry
   typedef struct packed {
      logic [`MCHAN_LEN_WIDTH-1:0]        len;
      logic [`MCHAN_OPC_WIDTH-1:0]        opc;
      logic                               inc;
      logic                               twd;
      logic                               ele;
      logic                               ile;
      logic                               ble;
      logic [`MCHAN_SID_WIDTH-1:0]        sid;
      logic [`MCHAN_TWD_COUNT_WIDTH-1:0]  count;
      logic [`MCHAN_TWD_STRIDE_WIDTH-1:0] stride;
   } cmd_entry_t;

   // Command offered downstream
   typedef struct packed {
      cmd_entry_t                       entry;
      logic [`MCHAN_TCDM_ADD_WIDTH-1:0] tcdm_add;
      logic [`MCHAN_EXT_ADD_WIDTH-1:0]  ext_add;
   } mchan_cmd_t;

endpackage

`default_nettype wire

//--- hdl/trans_allocator.sv
// SID pool and pending tracker
`default_nettype none
`include "mchan_cfg.svh"

module trans_allocator (
   input  wire logic                           clk_i,
   input  wire logic                           rst_n_i,
   input  wire logic                           alloc_req_i,
   output logic                                alloc_gnt_o,
   output logic [`MCHAN_SID_WIDTH-1:0]         alloc_sid_o,
   input  wire logic [`MCHAN_NB_TRANSFERS-1:0] free_i,
   input  wire logic                           issue_i,
   input  wire logic [`MCHAN_SID_WIDTH-1:0]    issue_sid_i,
   input  wire logic                           done_i,
   input  wire logic [`MCHAN_SID_WIDTH-1:0]    done_sid_i,
   output logic [`MCHAN_NB_TRANSFERS-1:0]      pending_o
);

   localparam int NB = `MCHAN_NB_TRANSFERS;
   localparam int SW = `MCHAN_SID_WIDTH;

   logic [NB-1:0] alloc_q;
   logic [NB-1:0] alloc_set;
   logic [NB-1:0] issue_set;
   logic [NB-1:0] done_clr;
   logic          any_free;

   //**********************************************************
   // Lowest free SID
   //**********************************************************
   always_comb begin
      alloc_sid_o = '0;
      any_free    = 1'b0;
      // Walk down so the lowest index wins
      for (int i = NB - 1; i >= 0; i--) begin
         if (!alloc_q[i]) begin
            alloc_sid_o = SW'(i);
            any_free    = 1'b1;
         end
      end
   end

   assign alloc_gnt_o = alloc_req_i & any_free;

   // One-hot set and clear masks
   assign alloc_set = alloc_gnt_o ? (NB'(1) << alloc_sid_o) : '0;
   assign issue_set = issue_i ? (NB'(1) << issue_sid_i) : '0;
   assign done_clr  = done_i ? (NB'(1) << done_sid_i) : '0;

   //**********************************************************
   // Allocation and pending vectors
   //**********************************************************
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         alloc_q   <= '0;
         pending_o <= '0;
      end else begin
         alloc_q   <= (alloc_q & ~free_i) | alloc_set;
         pending_o <= (pending_o | issue_set) & ~done_clr;
      end
   end

   // Engine completes only what was issued
   assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |-> pending_o[done_sid_i]);
   // Core may not release an SID still in flight
   assert property (@(posedge clk_i) disable iff (!rst_n_i) (free_i & pending_o) == '0);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the DMA channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mchan_tb -f vlog.f -o mchan_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/mchan_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1

//--- verification/mchan_clk_gen.sv
// Testbench clock source
`default_nettype none

module mchan_clk_gen #(
   parameter int PERIOD = 4
) (
   output logic clk_o
);

   // Free running, starts low
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

//--- verification/mchan_tb.sv
// DMA channel front end testbench
`default_nettype none
`include "mchan_cfg.svh"

module mchan_tb;

   localparam int          CLK_PERIOD     = 4;
   localparam int          TIMEOUT_CYCLES = 2000;
   localparam int          STALL_CYCLES   = 6;
   localparam int          NB             = `MCHAN_NB_TRANSFERS;
   localparam int          SW             = `MCHAN_SID_WIDTH;
   localparam logic [31:0] SEED           = 32'h458c_775a;
   localparam logic [1:0]  GNT_LOW        = 2'd0;
   localparam logic [1:0]  GNT_HIGH       = 2'd1;
   localparam logic [1:0]  GNT_RANDOM     = 2'd2;

   logic                  clk_i;
   logic                  rst_n_i;
   mchan_pkg::ctrl_req_t  ctrl_req;
   mchan_pkg::ctrl_rsp_t  ctrl_rsp;
   logic                  cmd_req_o;
   logic                  cmd_gnt_i = 1'b0;
   mchan_pkg::mchan_cmd_t cmd_o;
   logic                  done_i;
   logic [SW-1:0]         done_sid_i;
   logic                  busy_o;

   // Reference queue of expected commands
   mchan_pkg::mchan_cmd_t exp_mem [16];
   logic [3:0]            exp_head;
   logic [3:0]            exp_tail;
   // SID models, pending one feeds the assertions
   logic [NB-1:0]         alloc_model;
   logic [NB-1:0]         pend_model;
   logic [SW-1:0]         cur_sid;
   // Check enables and expected read data
   logic                  rd_chk;
   logic [31:0]           rd_exp;
   logic                  stall_chk;
   logic                  idle_chk;
   logic [1:0]            gnt_mode;
   logic [31:0]           stim_rng;
   logic [31:0]           gnt_rng = SEED;
   int                    errors = 0;
   int                    n_cmd;

   mchan_clk_gen #(.PERIOD(CLK_PERIOD)) i_clk_gen (.clk_o(clk_i));

   mchan_ctrl i_dut (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .ctrl_targ_i (ctrl_req),
      .ctrl_targ_o (ctrl_rsp),
      .cmd_req_o   (cmd_req_o),
      .cmd_gnt_i   (cmd_gnt_i),
      .cmd_o       (cmd_o),
      .done_i      (done_i),
      .done_sid_i  (done_sid_i),
      .busy_o      (busy_o)
   );

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Lowest unallocated SID, or -1 when the pool is empty
   function automatic int lowest_free(input logic [NB-1:0] used);
      for (int i = 0; i < NB; i++) begin
         if (!used[i])
            return i;
      end
      return -1;
   endfunction

   task automatic flag_error(input string msg);
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   //************************************************************
   // Downstream engine and reference pop
   //************************************************************
   always @(posedge clk_i) begin
      gnt_rng   <= lcg(gnt_rng);
      cmd_gnt_i <= (gnt_mode == GNT_RANDOM) ? gnt_rng[16] : (gnt_mode == GNT_HIGH);
   end

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         exp_head <= '0;
         n_cmd    <= 0;
      end else if (cmd_req_o && cmd_gnt_i) begin
         exp_head <= exp_head + 4'd1;
         n_cmd    <= n_cmd + 1;
      end
   end

   //************************************************************
   // Checks
   //************************************************************
   a_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      idle_chk |-> !cmd_req_o && !busy_o)
      else flag_error("channel not idle after reset");
   a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ctrl_rsp.r_valid && rd_chk |-> ctrl_rsp.r_data == rd_exp)
      else flag_error("read data differs from the register model");
   a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ctrl_req.req && ctrl_rsp.gnt |=> ctrl_rsp.r_valid)
      else flag_error("granted access without a response");
   a_cmd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_req_o && cmd_gnt_i |-> cmd_o == exp_mem[exp_head])
      else flag_error("issued command differs from the reference queue");
   a_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      exp_head == exp_tail |-> !cmd_req_o)
      else flag_error("command offered with nothing expected");
   a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      stall_chk |-> !ctrl_rsp.gnt)
      else flag_error("write granted into a full queue");
   a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pend_model != '0 |-> busy_o)
      else flag_error("busy low with a pending SID");

   //************************************************************
   // Bus access tasks
   //************************************************************
   // Returns on the edge that takes the access
   task automatic access(input logic rd, input logic [3:0] off, input logic [31:0] data,
                         input logic chk, input logic [31:0] exp);
      @(posedge clk_i);
      ctrl_req <= '{req: 1'b1, typ: rd, be: 4'hf, add: {28'd0, off}, data: data};
      rd_chk   <= chk;
      rd_exp   <= exp;
      @(negedge clk_i);
      while (!ctrl_rsp.gnt)
         @(negedge clk_i);
      @(posedge clk_i);
      ctrl_req.req <= 1'b0;
   endtask

   task automatic read_cmd();
      int idx;
      @(negedge clk_i);
      idx = lowest_free(alloc_model);
      if (idx < 0) begin
         access(1'b1, `MCHAN_CMD_OFFSET, '0, 1'b1, 32'h8000_0000);
      end else begin
         access(1'b1, `MCHAN_CMD_OFFSET, '0, 1'b1, 32'(idx));
         alloc_model[idx] = 1'b1;
         cur_sid          = SW'(idx);
      end
   endtask

   task automatic read_status();
      // Model settles on the falling edge
      @(negedge clk_i);
      access(1'b1, `MCHAN_STATUS_OFFSET, '0, 1'b1, {{(32 - NB){1'b0}}, pend_model});
   endtask

   task automatic free_sids(input logic [NB-1:0] mask);
      access(1'b0, `MCHAN_STATUS_OFFSET, {{(32 - NB){1'b0}}, mask}, 1'b0, '0);
      alloc_model = alloc_model & ~mask;
   endtask

   task automatic complete(input logic [SW-1:0] sid);
      @(posedge clk_i);
      done_i     <= 1'b1;
      done_sid_i <= sid;
      @(posedge clk_i);
      done_i         <= 1'b0;
      pend_model[sid] <= 1'b0;
   endtask

   // Random command, optionally stalling on its TCDM word
   task automatic send_cmd(input logic twd, input logic stall);
      logic [31:0]           r0;
      logic [31:0]           r1;
      logic [31:0]           r2;
      logic [31:0]           r3;
      mchan_pkg::mchan_cmd_t exp;
      stim_rng = lcg(stim_rng);
      r0       = stim_rng;
      stim_rng = lcg(stim_rng);
      r1       = stim_rng;
      stim_rng = lcg(stim_rng);
      r2       = stim_rng;
      stim_rng = lcg(stim_rng);
      r3       = stim_rng;
      exp.entry.len    = r0[15:0];
      exp.entry.opc    = r0[16];
      exp.entry.inc    = r0[17];
      exp.entry.twd    = twd;
      exp.entry.ele    = r0[19];
      exp.entry.ile    = r0[20];
      exp.entry.ble    = r0[21];
      exp.entry.sid    = cur_sid;
      exp.entry.count  = twd ? r2[15:0] : '0;
      exp.entry.stride = twd ? r2[31:16] : '0;
      exp.tcdm_add     = r1[11:0];
      exp.ext_add      = r3[28:0];
      @(posedge clk_i);
      exp_mem[exp_tail] <= exp;
      exp_tail          <= exp_tail + 4'd1;
      // Command word, bit 18 carries twd
      access(1'b0, `MCHAN_CMD_OFFSET, {10'd0, r0[21:19], twd, r0[17:0]}, 1'b0, '0);
      if (stall) begin
         fork
            access(1'b0, `MCHAN_CMD_OFFSET, r1, 1'b0, '0);
            begin
               @(posedge clk_i);
               stall_chk <= 1'b1;
               repeat (STALL_CYCLES) @(posedge clk_i);
               stall_chk <= 1'b0;
               gnt_mode  <= GNT_RANDOM;
            end
         join
      end else begin
         access(1'b0, `MCHAN_CMD_OFFSET, r1, 1'b0, '0);
      end
      access(1'b0, `MCHAN_CMD_OFFSET, r3, 1'b0, '0);
      if (twd)
         access(1'b0, `MCHAN_CMD_OFFSET, r2, 1'b0, '0);
      pend_model[cur_sid] <= 1'b1;
   endtask

   task automatic wait_drained();
      while (exp_head != exp_tail)
         @(posedge clk_i);
   endtask

   //************************************************************
   // Watchdog
   //************************************************************
   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles with the tests unfinished", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
   end

   //************************************************************
   // Test sequence
   //************************************************************
   initial begin
      rst_n_i     = 1'b0;
      ctrl_req    = '0;
      done_i      = 1'b0;
      done_sid_i  = '0;
      gnt_mode    = GNT_HIGH;
      exp_tail    = '0;
      alloc_model = '0;
      pend_model  = '0;
      cur_sid     = '0;
      rd_chk      = 1'b0;
      rd_exp      = '0;
      stall_chk   = 1'b0;
      idle_chk    = 1'b0;
      stim_rng    = SEED;
      repeat (10) @(posedge clk_i);
      rst_n_i <= 1'b1;
      // Idle state after reset
      @(posedge clk_i);
      idle_chk <= 1'b1;
      @(posedge clk_i);
      idle_chk <= 1'b0;
      read_status();
      // Drain the SID pool, then one refused read
      repeat (NB + 1) read_cmd();
      // 1D and 2D commands with the engine always ready
      send_cmd(1'b0, 1'b0);
      send_cmd(1'b1, 1'b0);
      wait_drained();
      read_status();
      complete(cur_sid);
      read_status();
      free_sids(4'b0110);
      read_cmd();
      // Two commands fill the queues, the third stalls
      @(posedge clk_i);
      gnt_mode <= GNT_LOW;
      send_cmd(1'b0, 1'b0);
      send_cmd(1'b1, 1'b0);
      send_cmd(1'b0, 1'b1);
      send_cmd(1'b1, 1'b0);
      send_cmd(1'b0, 1'b0);
      wait_drained();
      read_status();
      complete(cur_sid);
      read_status();
      // Lowest freed SID first
      free_sids(4'b1010);
      read_cmd();
      read_cmd();
      read_cmd();
      repeat (5) @(posedge clk_i);
      $display("Summary: %0d commands issued, %0d errors", n_cmd, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/mchan_pkg.sv
hdl/mchan_fifo.sv
hdl/trans_allocator.sv
hdl/address_decoder.sv
hdl/core_if.sv
hdl/mchan_ctrl.sv
verification/mchan_clk_gen.sv
verification/mchan_tb.sv
